// File: Makefile
# Verilator flow for the L1 cache testbench
# make        build and run, result taken from the log
# make lint   lint the cache RTL
# make clean  remove build output and log

VERILATOR ?= verilator
TOP       ?= tb_l1_cache
DUT_TOP   ?= l1_cache
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall
FAIL_MSG  := STATUS: FAIL
PASS_MSG  := STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation gave no result"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
hdl/l1_cache_pkg.sv
hdl/cache_tag_array.sv
hdl/cache_data_array.sv
hdl/cache_controller.sv
hdl/l1_cache.sv
verif/tb_l1_cache.sv

// File: hdl/cache_controller.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache controller with address decode, hit completion, uncached
// routing and the writeback and fetch FSM that drives the memory bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_controller
    import l1_cache_pkg::*;
#(
    parameter int    CACHE_SIZE          = 1024,
    parameter int    BLOCK_SIZE          = 2,
    parameter int    ASSOC               = 1,
    parameter word_t NONCACHE_START_ADDR = 32'h8000_0000,
    localparam int   N_SETS     = CACHE_SIZE / (BLOCK_SIZE * N_LANES) / ASSOC,
    localparam int   SET_BITS   = $clog2(N_SETS),
    localparam int   BLOCK_BITS = $clog2(BLOCK_SIZE),
    localparam int   SET_W      = (SET_BITS > 0) ? SET_BITS : 1,
    localparam int   OFF_W      = (BLOCK_BITS > 0) ? BLOCK_BITS : 1,
    localparam int   TAG_W      = WORD_SIZE - SET_BITS - BLOCK_BITS - 2
) (
    input  logic             CLK,
    input  logic             nRST,
    // processor side
    input  logic             proc_ren,
    input  logic             proc_wen,
    input  word_t            proc_addr,
    input  word_t            proc_wdata,
    input  byte_en_t         proc_byte_en,
    output logic             proc_busy,
    output word_t            proc_rdata,
    // tag array
    input  logic             hit,
    input  logic             hit_way,
    input  logic             victim_way,
    input  logic             victim_dirty,
    input  logic [TAG_W-1:0] victim_tag,
    output logic [SET_W-1:0] set_idx,
    output logic [TAG_W-1:0] req_tag,
    output logic             touch,
    output logic             mark_dirty,
    output logic             fill_done,
    output logic             clean,
    output logic             upd_way,
    // data array
    input  word_t            rdata_hit,
    input  word_t            victim_data,
    output logic [OFF_W-1:0] word_off,
    output logic [OFF_W-1:0] cnt_off,      // fill and writeback offset
    output logic             wr_hit,
    output logic             wr_fill,
    // memory side
    output logic             mem_ren,
    output logic             mem_wen,
    output word_t            mem_addr,
    output word_t            mem_wdata,
    output byte_en_t         mem_byte_en,
    input  word_t            mem_rdata,
    input  logic             mem_busy
);

    localparam int CNT_W   = BLOCK_BITS + 1;            // counts up to BLOCK_SIZE
    localparam int SET_LSB = BLOCK_BITS + 2;
    localparam int TAG_LSB = SET_BITS + BLOCK_BITS + 2;

    typedef logic [CNT_W-1:0] cnt_t;

    cache_state_t state, next_state;
    cnt_t         word_cnt, next_word_cnt;
    logic         req, pass, cnt_done;
    word_t        wb_addr, fill_addr, pass_wdata;

    // address split of the request, held stable through a miss
    assign req_tag  = TAG_W'(proc_addr >> TAG_LSB);
    assign set_idx  = SET_W'((proc_addr >> SET_LSB) & word_t'(N_SETS - 1));
    assign word_off = OFF_W'((proc_addr >> 2) & word_t'(BLOCK_SIZE - 1));

    assign req      = proc_ren | proc_wen;
    assign pass     = (proc_addr >= NONCACHE_START_ADDR);   // uncached window
    assign cnt_done = (word_cnt == CNT_W'(BLOCK_SIZE));
    assign cnt_off  = word_cnt[OFF_W-1:0];

    // victim goes back to its own block and fill reads the request block
    assign wb_addr   = (word_t'(victim_tag) << TAG_LSB) | (word_t'(set_idx) << SET_LSB)
                     | (word_t'(cnt_off) << 2);
    assign fill_addr = (word_t'(req_tag) << TAG_LSB) | (word_t'(set_idx) << SET_LSB)
                     | (word_t'(cnt_off) << 2);

    // disabled lanes go out as zero on uncached writes
    always_comb begin
        for (int b = 0; b < N_LANES; b++)
            pass_wdata[b*8 +: 8] = proc_byte_en[b] ? proc_wdata[b*8 +: 8] : 8'h00;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            word_cnt <= '0;
        end else begin
            state    <= next_state;
            word_cnt <= next_word_cnt;
        end
    end

    always_comb begin
        next_state    = state;
        next_word_cnt = word_cnt;
        proc_busy     = 1'b1;
        proc_rdata    = rdata_hit;
        touch         = 1'b0;
        mark_dirty    = 1'b0;
        fill_done     = 1'b0;
        clean         = 1'b0;
        upd_way       = victim_way;    // block being replaced
        wr_hit        = 1'b0;
        wr_fill       = 1'b0;
        mem_ren       = 1'b0;
        mem_wen       = 1'b0;
        mem_addr      = fill_addr;
        mem_wdata     = victim_data;
        mem_byte_en   = '1;            // whole words on block moves
        case (state)
            IDLE: begin
                upd_way = hit_way;
                if (pass) begin
                    mem_ren     = proc_ren;
                    mem_wen     = proc_wen;
                    mem_addr    = proc_addr;
                    mem_wdata   = pass_wdata;
                    mem_byte_en = proc_byte_en;
                    proc_rdata  = mem_rdata;
                    if (req)
                        proc_busy = mem_busy;  // done when memory takes it
                end else if (req && hit) begin
                    proc_busy  = 1'b0;
                    touch      = 1'b1;
                    wr_hit     = proc_wen;
                    mark_dirty = proc_wen;
                end else if (req) begin
                    next_state = victim_dirty ? WB : FETCH;
                end
            end
            WB: begin
                mem_addr = wb_addr;
                if (cnt_done) begin
                    clean         = 1'b1;
                    next_word_cnt = '0;
                    next_state    = FETCH;
                end else begin
                    mem_wen = 1'b1;
                    if (!mem_busy)
                        next_word_cnt = word_cnt + 1'b1;
                end
            end
            FETCH: begin
                if (cnt_done) begin
                    fill_done     = 1'b1;   // hit completes back in IDLE
                    next_word_cnt = '0;
                    next_state    = IDLE;
                end else begin
                    mem_ren = 1'b1;
                    if (!mem_busy) begin
                        wr_fill       = 1'b1;
                        next_word_cnt = word_cnt + 1'b1;
                    end
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // uncached requests carry one strobe from the processor
    a_one_strobe : assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else $error("controller: mem_ren and mem_wen together");

    // a stalled block transfer keeps its strobe and address
    a_hold_on_busy : assert property (@(posedge CLK) disable iff (!nRST)
        (state != IDLE && (mem_ren || mem_wen) && mem_busy)
            |=> ($stable(mem_addr) && (mem_ren || mem_wen)))
        else $error("controller: memory request changed while busy");

endmodule : cache_controller

`default_nettype wire

// File: hdl/cache_data_array.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data side of the cache: block words per way and set, read mux,
// byte merge for write hits and whole word writes for fills
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_data_array
    import l1_cache_pkg::*;
#(
    parameter int    CACHE_SIZE = 1024,
    parameter int    BLOCK_SIZE = 2,
    parameter int    ASSOC      = 1,
    localparam int   N_SETS     = CACHE_SIZE / (BLOCK_SIZE * N_LANES) / ASSOC,
    localparam int   SET_BITS   = $clog2(N_SETS),
    localparam int   BLOCK_BITS = $clog2(BLOCK_SIZE),
    localparam int   SET_W      = (SET_BITS > 0) ? SET_BITS : 1,
    localparam int   OFF_W      = (BLOCK_BITS > 0) ? BLOCK_BITS : 1
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic [SET_W-1:0] set_idx,
    input  logic [OFF_W-1:0] word_off,     // word of the request in its block
    input  logic             wr_hit,       // processor write on a hit
    input  logic             hit_way,
    input  byte_en_t         byte_en,
    input  word_t            wdata,
    input  logic             wr_fill,      // one word from memory
    input  logic             fill_way,
    input  logic [OFF_W-1:0] fill_off,
    input  word_t            fill_data,
    input  logic             victim_way,
    input  logic [OFF_W-1:0] wb_off,       // word being written back
    output word_t            rdata,
    output word_t            victim_data
);

    word_t data_mem [N_SETS][ASSOC][BLOCK_SIZE];  // payload, no reset
    word_t merged;                                // hit word with new lanes

    assign rdata       = data_mem[set_idx][hit_way][word_off];
    assign victim_data = data_mem[set_idx][victim_way][wb_off];

    // lane merge, any mask pattern
    always_comb begin
        merged = rdata;
        for (int b = 0; b < N_LANES; b++) begin
            if (byte_en[b])
                merged[b*8 +: 8] = wdata[b*8 +: 8];
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_fill)
            data_mem[set_idx][fill_way][fill_off] <= fill_data;
        else if (wr_hit)
            data_mem[set_idx][hit_way][word_off] <= merged;
    end

    // hits complete only in IDLE, fills only in FETCH
    a_one_writer : assert property (@(posedge CLK) disable iff (!nRST)
        !(wr_hit && wr_fill))
        else $error("data array: hit write and fill write together");

endmodule : cache_data_array

`default_nettype wire

// File: hdl/cache_tag_array.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tag side of the cache: valid, dirty, tag and lru per set,
// combinational hit check and victim pick, updates on the clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cache_tag_array
    import l1_cache_pkg::*;
#(
    parameter int    CACHE_SIZE = 1024,    // bytes
    parameter int    BLOCK_SIZE = 2,       // words per block
    parameter int    ASSOC      = 1,       // 1 or 2 ways
    localparam int   N_SETS     = CACHE_SIZE / (BLOCK_SIZE * N_LANES) / ASSOC,
    localparam int   SET_BITS   = $clog2(N_SETS),
    localparam int   BLOCK_BITS = $clog2(BLOCK_SIZE),
    localparam int   SET_W      = (SET_BITS > 0) ? SET_BITS : 1,
    localparam int   TAG_W      = WORD_SIZE - SET_BITS - BLOCK_BITS - 2
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic [SET_W-1:0] set_idx,      // set of the current request
    input  logic [TAG_W-1:0] req_tag,      // tag of the current request
    input  logic             touch,        // record use of touch_way
    input  logic             touch_way,
    input  logic             mark_dirty,   // write hit on upd_way
    input  logic             fill_done,    // block now holds req_tag
    input  logic             clean,        // writeback finished
    input  logic             upd_way,
    output logic             hit,
    output logic             hit_way,
    output logic             victim_way,
    output logic             victim_dirty,
    output logic [TAG_W-1:0] victim_tag
);

    typedef logic [TAG_W-1:0] tag_t;

    tag_t tag_mem [N_SETS][ASSOC];   // no reset, qualified by valid
    logic valid   [N_SETS][ASSOC];
    logic dirty   [N_SETS][ASSOC];
    logic lru     [N_SETS];          // way used last in each set

    // control bits
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                lru[s] <= 1'b0;
                for (int w = 0; w < ASSOC; w++) begin
                    valid[s][w] <= 1'b0;
                    dirty[s][w] <= 1'b0;
                end
            end
        end else begin
            if (touch)
                lru[set_idx] <= touch_way;
            if (mark_dirty)
                dirty[set_idx][upd_way] <= 1'b1;
            if (fill_done) begin
                valid[set_idx][upd_way] <= 1'b1;
                dirty[set_idx][upd_way] <= 1'b0;   // fresh copy of memory
            end
            if (clean)
                dirty[set_idx][upd_way] <= 1'b0;
        end
    end

    // tag written with the block's valid bit
    always_ff @(posedge CLK) begin
        if (fill_done)
            tag_mem[set_idx][upd_way] <= req_tag;
    end

    // hit check over all ways of the set
    always_comb begin
        hit     = 1'b0;
        hit_way = 1'b0;
        for (int w = 0; w < ASSOC; w++) begin
            if (valid[set_idx][w] && (tag_mem[set_idx][w] == req_tag)) begin
                hit     = 1'b1;
                hit_way = 1'(w);
            end
        end
    end

    // replace the way not used last, direct mapped has only way 0
    assign victim_way   = (ASSOC == 1) ? 1'b0 : ~lru[set_idx];
    assign victim_dirty = valid[set_idx][victim_way] & dirty[set_idx][victim_way];
    assign victim_tag   = tag_mem[set_idx][victim_way];

    // the fill ends a miss, so the request tag cannot already sit in the set
    a_fill_on_miss : assert property (@(posedge CLK) disable iff (!nRST)
        fill_done |-> !hit)
        else $error("tag array: fill_done while request hits");

endmodule : cache_tag_array

`default_nettype wire

// File: hdl/l1_cache.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write-back L1 cache top, set the geometry here and hook the
// processor word bus and the memory word bus to the ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module l1_cache
    import l1_cache_pkg::*;
#(
    parameter int    CACHE_SIZE          = 1024,          // bytes, power of 2
    parameter int    BLOCK_SIZE          = 2,             // words, power of 2, max 8
    parameter int    ASSOC               = 1,             // 1 or 2
    parameter word_t NONCACHE_START_ADDR = 32'h8000_0000  // uncached from here up
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     proc_ren,
    input  logic     proc_wen,
    input  word_t    proc_addr,
    input  word_t    proc_wdata,
    input  byte_en_t proc_byte_en,
    output word_t    proc_rdata,
    output logic     proc_busy,
    output logic     mem_ren,
    output logic     mem_wen,
    output word_t    mem_addr,
    output word_t    mem_wdata,
    output byte_en_t mem_byte_en,
    input  word_t    mem_rdata,
    input  logic     mem_busy
);

    localparam int N_SETS     = CACHE_SIZE / (BLOCK_SIZE * N_LANES) / ASSOC;
    localparam int SET_BITS   = $clog2(N_SETS);
    localparam int BLOCK_BITS = $clog2(BLOCK_SIZE);
    localparam int SET_W      = (SET_BITS > 0) ? SET_BITS : 1;
    localparam int OFF_W      = (BLOCK_BITS > 0) ? BLOCK_BITS : 1;
    localparam int TAG_W      = WORD_SIZE - SET_BITS - BLOCK_BITS - 2;

    logic [SET_W-1:0] set_idx;
    logic [TAG_W-1:0] req_tag, victim_tag;
    logic [OFF_W-1:0] word_off, cnt_off;
    logic             hit, hit_way, victim_way, victim_dirty;
    logic             touch, mark_dirty, fill_done, clean, upd_way;
    logic             wr_hit, wr_fill;
    word_t            rdata_hit, victim_data;

    cache_controller #(
        .CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE), .ASSOC(ASSOC),
        .NONCACHE_START_ADDR(NONCACHE_START_ADDR)
    ) u_ctrl (
        .CLK, .nRST,
        .proc_ren, .proc_wen, .proc_addr, .proc_wdata, .proc_byte_en,
        .proc_busy, .proc_rdata,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .set_idx, .req_tag, .touch, .mark_dirty, .fill_done, .clean, .upd_way,
        .rdata_hit, .victim_data, .word_off, .cnt_off, .wr_hit, .wr_fill,
        .mem_ren, .mem_wen, .mem_addr, .mem_wdata, .mem_byte_en,
        .mem_rdata, .mem_busy
    );

    cache_tag_array #(
        .CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE), .ASSOC(ASSOC)
    ) u_tags (
        .CLK, .nRST, .set_idx, .req_tag,
        .touch, .touch_way(hit_way),          // lru follows the hit way
        .mark_dirty, .fill_done, .clean, .upd_way,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
    );

    cache_data_array #(
        .CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE), .ASSOC(ASSOC)
    ) u_data (
        .CLK, .nRST, .set_idx, .word_off,
        .wr_hit, .hit_way, .byte_en(proc_byte_en), .wdata(proc_wdata),
        .wr_fill, .fill_way(victim_way), .fill_off(cnt_off),
        .fill_data(mem_rdata),                // fill words straight off the bus
        .victim_way, .wb_off(cnt_off),
        .rdata(rdata_hit), .victim_data
    );

endmodule : l1_cache

`default_nettype wire

// File: hdl/l1_cache_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// common types for the L1 cache, imported by every cache module
// and by the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package l1_cache_pkg;

    // word geometry
    parameter int WORD_SIZE = 32;               // bits per data word
    parameter int N_LANES   = WORD_SIZE / 8;    // byte lanes per word

    // one data word, also used for byte addresses
    typedef logic [WORD_SIZE-1:0] word_t;

    // one enable bit per byte lane
    typedef logic [N_LANES-1:0] byte_en_t;

    // controller states
    // IDLE  : lookup, hit completion and uncached routing
    // WB    : dirty victim block goes out word by word
    // FETCH : missing block comes in word by word
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        WB    = 2'd1,
        FETCH = 2'd2
    } cache_state_t;

endpackage : l1_cache_pkg

`default_nettype wire

// File: verif/l1_cache_tests.txt
# op addr be wdata exp_rdata fill, all hex, one request per line
# be and wdata unused on reads, exp_rdata unused on writes
R 00000100 f 00000000 c0de0040 1
W 00000100 1 11223344 00000000 0
R 00000100 f 00000000 c0de0044 0
W 00000100 6 aabbccdd 00000000 0
R 00000100 f 00000000 c0bbcc44 0
W 00000100 f 12345678 00000000 0
R 00000100 f 00000000 12345678 0
R 00000208 f 00000000 c0de0082 1
R 00000288 f 00000000 c0de00a2 1
R 00000208 f 00000000 c0de0082 0
R 00000308 f 00000000 c0de00c2 1
R 00000208 f 00000000 c0de0082 0
R 0000020c f 00000000 c0de0083 0
R 00000288 f 00000000 c0de00a2 1
W 00000410 f deadbeef 00000000 1
W 00000414 3 0000a5a5 00000000 0
R 00000490 f 00000000 c0de0124 1
R 00000510 f 00000000 c0de0144 1
R 00000410 f 00000000 deadbeef 1
R 00000414 f 00000000 c0dea5a5 0
W 80000010 a 11223344 00000000 0
R 80000010 f 00000000 11de3304 0
R 80000100 f 00000000 e0de0040 0

// File: verif/tb_l1_cache.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the L1 cache that replays the requests of the tests
// file against a word memory model with random busy stretches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_l1_cache
    import l1_cache_pkg::*;
();

    localparam int    CACHE_SIZE = 256;
    localparam int    BLOCK_SIZE = 2;
    localparam int    ASSOC      = 2;
    localparam word_t NC_START   = 32'h8000_0000;   // uncached window base
    localparam int    TIMEOUT    = 200;             // cycles per request

    logic       CLK = 1'b0;
    logic       nRST;
    logic       proc_ren, proc_wen;
    word_t      proc_addr, proc_wdata;
    byte_en_t   proc_byte_en;
    word_t      proc_rdata;
    logic       proc_busy;
    logic       mem_ren, mem_wen;
    word_t      mem_addr, mem_wdata;
    byte_en_t   mem_byte_en;
    word_t      mem_rdata = '0;
    logic       mem_busy  = 1'b0;

    // memory model
    word_t      mem_store [word_t];     // written words only, rest is pattern
    int         mem_version = 0;        // bumps on every applied write
    int         read_words  = 0;        // mem_ren words so far
    logic [1:0] wait_left   = 2'd0;     // busy cycles left for next word
    integer     seed        = 32'ha778;
    logic       wr_pend     = 1'b0;     // write taken at the last rising edge
    word_t      wr_addr, wr_data, wr_word;
    byte_en_t   wr_be;

    always #4 CLK = ~CLK;

    l1_cache #(
        .CACHE_SIZE(CACHE_SIZE), .BLOCK_SIZE(BLOCK_SIZE), .ASSOC(ASSOC),
        .NONCACHE_START_ADDR(NC_START)
    ) uut (
        .CLK, .nRST,
        .proc_ren, .proc_wen, .proc_addr, .proc_wdata, .proc_byte_en,
        .proc_rdata, .proc_busy,
        .mem_ren, .mem_wen, .mem_addr, .mem_wdata, .mem_byte_en,
        .mem_rdata, .mem_busy
    );

    // unwritten words read as word address xor a marker
    function automatic word_t stored_word(word_t addr);
        word_t idx;
        idx = addr >> 2;
        if (mem_store.exists(idx) != 0)
            return mem_store[idx];
        return idx ^ 32'hc0de_0000;
    endfunction

    // only the enabled lanes of a word, the rest zero
    function automatic word_t enabled_lanes(word_t data, byte_en_t be);
        word_t res;
        res = '0;
        for (int b = 0; b < N_LANES; b++) begin
            if (be[b])
                res[b*8 +: 8] = data[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_word(string name, word_t got, word_t exp);
        if (got !== exp)
            stop_on_error($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic expect_flag(string name, logic got, logic exp);
        if (got !== exp)
            stop_on_error($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic verify_lanes(string name, byte_en_t got, byte_en_t exp);
        if (got !== exp)
            stop_on_error($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    // read data follows the address without waiting for a clock
    always @(mem_addr, mem_version)
        mem_rdata = stored_word(mem_addr);

    // a word moves on a rising edge with a strobe and busy low
    always @(posedge CLK) begin
        wr_pend <= 1'b0;
        if (mem_ren || mem_wen) begin
            if (!mem_busy) begin
                if (mem_addr < NC_START)
                    verify_lanes("mem_byte_en", mem_byte_en, '1);   // block moves
                if (mem_wen) begin
                    // uncached write carries zeros in its disabled lanes
                    if (mem_addr >= NC_START)
                        compare_word("mem_wdata", mem_wdata,
                                     enabled_lanes(proc_wdata, proc_byte_en));
                    wr_pend <= 1'b1;
                    wr_addr <= mem_addr;
                    wr_data <= mem_wdata;
                    wr_be   <= mem_byte_en;
                end
                if (mem_ren)
                    read_words <= read_words + 1;
                wait_left <= 2'($random(seed));   // 0 to 3 for the next word
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    // writes land half a cycle later, busy changes on the falling edge
    always @(negedge CLK) begin
        if (wr_pend) begin
            wr_word = stored_word(wr_addr);
            for (int b = 0; b < N_LANES; b++) begin
                if (wr_be[b])
                    wr_word[b*8 +: 8] = wr_data[b*8 +: 8];
            end
            mem_store[wr_addr >> 2] = wr_word;
            mem_version = mem_version + 1;
        end
        mem_busy = (wait_left != 2'd0);
    end

    // one request held until proc_busy is seen low on a rising edge
    task automatic run_request(input logic is_write, input word_t addr, input byte_en_t be,
                               input word_t wdata, output word_t rdata, output logic filled);
        int cycles;
        int reads_before;
        cycles = 0;
        @(negedge CLK);
        proc_ren     = ~is_write;
        proc_wen     = is_write;
        proc_addr    = addr;
        proc_wdata   = wdata;
        proc_byte_en = be;
        reads_before = read_words;
        @(posedge CLK);
        while (proc_busy) begin
            cycles++;
            if (cycles > TIMEOUT)
                stop_on_error($sformatf("timeout, proc_busy stuck high for address 0x%h", addr));
            @(posedge CLK);
        end
        rdata  = proc_rdata;
        // a block fill reads a whole block, an uncached read one word
        filled = ((read_words - reads_before) >= BLOCK_SIZE);
        @(negedge CLK);
        proc_ren = 1'b0;
        proc_wen = 1'b0;
    endtask

    initial begin
        int        fd;
        int        n;
        int        lineno;
        int        n_run;
        string     line;
        logic [7:0] op;
        word_t     addr, wdata, exp_data, got_data;
        byte_en_t  be;
        logic      exp_fill, got_fill;

        nRST         = 1'b0;
        proc_ren     = 1'b0;
        proc_wen     = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        proc_byte_en = '0;
        lineno       = 0;
        n_run        = 0;

        fd = $fopen("verif/l1_cache_tests.txt", "r");
        if (fd == 0)
            stop_on_error("could not open the test file verif/l1_cache_tests.txt");

        repeat (5) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        @(posedge CLK);
        expect_flag("mem_ren", mem_ren, 1'b0);      // bus quiet after reset
        expect_flag("mem_wen", mem_wen, 1'b0);
        expect_flag("proc_busy", proc_busy, 1'b1);  // nothing completes

        while ($fgets(line, fd) != 0) begin
            lineno++;
            if (line.len() > 1 && line.getc(0) != "#") begin
                op = line.getc(0);
                n  = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                             addr, be, wdata, exp_data, exp_fill);
                if (n != 5 || (op != "R" && op != "W"))
                    stop_on_error($sformatf("malformed line %0d in the test file", lineno));
                run_request(op == "W", addr, be, wdata, got_data, got_fill);
                if (op == "R")
                    compare_word($sformatf("proc_rdata (line %0d)", lineno), got_data, exp_data);
                expect_flag($sformatf("fill (line %0d)", lineno), got_fill, exp_fill);
                n_run++;
            end
        end
        $fclose(fd);

        if (n_run == 0)
            stop_on_error("the test file holds no requests");
        $display("%0d requests checked", n_run);
        $display("STATUS: PASS");
        $finish;
    end

endmodule : tb_l1_cache

`default_nettype wire
